// ==== Bender.yml ====
package:
  name: keyer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/keyer_pkg.sv
      - logic/pipe_delay.sv
      - logic/chroma_key.sv
      - logic/centroid_divider.sv
      - logic/centroid_tracker.sv
      - logic/overlay_mux.sv
      - logic/keyer_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clock_gen.sv
      - verification/keyer_tb.sv

// ==== logic/centroid_divider.sv ====
`timescale 1ns/100ps
`include "keyer_consts.svh"

module centroid_divider (
  input  logic                      clk_pixel,
  input  logic                      recent_reset,
  input  logic                      start_i,
  input  logic [`KEYER_SUM_W-1:0]   dividend_i,
  input  logic [`KEYER_COUNT_W-1:0] divisor_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [`KEYER_SUM_W-1:0]   quotient_o
);

  localparam int SUM_W   = `KEYER_SUM_W;
  localparam int COUNT_W = `KEYER_COUNT_W;
  localparam int STEP_W  = $clog2(SUM_W);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(SUM_W - 1);

  // quotient register doubles as the dividend shifter
  logic [SUM_W-1:0]   quo_q;
  logic [COUNT_W-1:0] rem_q;
  logic [COUNT_W-1:0] div_q;
  logic [STEP_W-1:0]  step_q;
  logic [COUNT_W:0]   trial;
  logic [COUNT_W:0]   diff;
  logic               fits;

  // bring down the next dividend bit and try a subtract
  assign trial = {rem_q, quo_q[SUM_W-1]};
  assign diff  = trial - {1'b0, div_q};
  assign fits  = trial >= {1'b0, div_q};

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      step_q <= '0;
    end else begin
      done_o <= 1'b0;
      if (!busy_o && start_i) begin
        busy_o <= 1'b1;
        step_q <= LAST_STEP;
      end else if (busy_o) begin
        step_q <= step_q - 1'b1;
        // last quotient bit lands on this edge
        if (step_q == '0) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // operands and partial results
  always_ff @(posedge clk_pixel) begin
    if (!busy_o && start_i) begin
      quo_q <= dividend_i;
      rem_q <= '0;
      div_q <= divisor_i;
    end else if (busy_o) begin
      // restore by simply keeping the unsubtracted trial
      rem_q <= fits ? diff[COUNT_W-1:0] : trial[COUNT_W-1:0];
      quo_q <= {quo_q[SUM_W-2:0], fits};
    end
  end

  assign quotient_o = quo_q;

endmodule

// ==== logic/centroid_tracker.sv ====
`timescale 1ns/100ps
`include "keyer_consts.svh"

module centroid_tracker (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  input  keyer_pkg::raster_t  tag_i,
  input  logic                player_i,
  output keyer_pkg::hcount_t  com_x_o,
  output keyer_pkg::vcount_t  com_y_o,
  output logic                com_valid_o
);

  localparam int SUM_W   = `KEYER_SUM_W;
  localparam int COUNT_W = `KEYER_COUNT_W;

  logic [SUM_W-1:0]   x_sum_q;
  logic [SUM_W-1:0]   y_sum_q;
  logic [COUNT_W-1:0] count_q;
  logic               launch;
  logic               x_busy;
  logic               y_busy;
  logic               x_done;
  logic               y_done;
  logic [SUM_W-1:0]   x_quo;
  logic [SUM_W-1:0]   y_quo;

  // ==========================================================================
  // per frame accumulation
  // ==========================================================================

  // divide only when there is something to average and both units are free
  // otherwise this frame's result is simply lost
  assign launch = tag_i.frame_end && (count_q != '0) && !x_busy && !y_busy;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      x_sum_q <= '0;
      y_sum_q <= '0;
      count_q <= '0;
    end else if (tag_i.frame_end) begin
      // dividers latch the sums on this same edge
      x_sum_q <= '0;
      y_sum_q <= '0;
      count_q <= '0;
    end else if (tag_i.active && player_i) begin
      x_sum_q <= x_sum_q + SUM_W'(tag_i.hcount);
      y_sum_q <= y_sum_q + SUM_W'(tag_i.vcount);
      count_q <= count_q + COUNT_W'(1);
    end
  end

  // ==========================================================================
  // mean per axis
  // ==========================================================================
  centroid_divider u_div_x (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .start_i      (launch),
    .dividend_i   (x_sum_q),
    .divisor_i    (count_q),
    .busy_o       (x_busy),
    .done_o       (x_done),
    .quotient_o   (x_quo)
  );

  centroid_divider u_div_y (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .start_i      (launch),
    .dividend_i   (y_sum_q),
    .divisor_i    (count_q),
    .busy_o       (y_busy),
    .done_o       (y_done),
    .quotient_o   (y_quo)
  );

  // both start together with equal latency, so done arrives together
  // a mean never exceeds the largest coordinate, upper bits are zero
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      com_x_o     <= '0;
      com_y_o     <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= x_done && y_done;
      if (x_done && y_done) begin
        com_x_o <= x_quo[`KEYER_HCOUNT_W-1:0];
        com_y_o <= y_quo[`KEYER_VCOUNT_W-1:0];
      end
    end
  end

endmodule

// ==== logic/chroma_key.sv ====
`timescale 1ns/100ps
`include "keyer_consts.svh"

module chroma_key (
  input  logic                clk_pixel,
  input  logic                recent_reset,
  input  keyer_pkg::rgb565_t  pixel_i,
  input  logic [7:0]          cr_upper_i,
  input  logic [7:0]          cb_upper_i,
  output keyer_pkg::rgb888_t  color_o,
  output logic                player_o
);

  // weights as 9 bit signed so each product is a plain 9x9 multiply
  localparam logic signed [8:0]  W_CR_R = 9'(`KEYER_CR_R);
  localparam logic signed [8:0]  W_CR_G = 9'(`KEYER_CR_G);
  localparam logic signed [8:0]  W_CR_B = 9'(`KEYER_CR_B);
  localparam logic signed [8:0]  W_CB_R = 9'(`KEYER_CB_R);
  localparam logic signed [8:0]  W_CB_G = 9'(`KEYER_CB_G);
  localparam logic signed [8:0]  W_CB_B = 9'(`KEYER_CB_B);
  localparam logic signed [17:0] CHROMA_OFFSET = 18'(`KEYER_CHROMA_OFFSET);

  keyer_pkg::rgb888_t color_q;
  logic signed [17:0] cr_prod_q [3];
  logic signed [17:0] cb_prod_q [3];
  logic signed [17:0] cr_sum;
  logic signed [17:0] cb_sum;
  logic [7:0]         cr_q;
  logic [7:0]         cb_q;

  // scale down, recentre and saturate to one byte
  function automatic logic [7:0] clip_chroma(input logic signed [17:0] sum);
    logic signed [17:0] level;
    level = (sum >>> 8) + CHROMA_OFFSET;
    if (level < 0) begin
      return 8'h00;
    end else if (level > 18'sd255) begin
      return 8'hFF;
    end
    return level[7:0];
  endfunction

  // ==========================================================================
  // stage 1: widen 5:6:5 to 8:8:8 with zero low bits
  // ==========================================================================
  always_ff @(posedge clk_pixel) begin
    color_q.red   <= {pixel_i[15:11], 3'b000};
    color_q.green <= {pixel_i[10:5], 2'b00};
    color_q.blue  <= {pixel_i[4:0], 3'b000};
  end

  // ==========================================================================
  // stages 2 and 3: weighted products, then sum and clip
  // ==========================================================================
  always_ff @(posedge clk_pixel) begin
    // channels are unsigned, so prepend a zero before going signed
    cr_prod_q[0] <= $signed({1'b0, color_q.red}) * W_CR_R;
    cr_prod_q[1] <= $signed({1'b0, color_q.green}) * W_CR_G;
    cr_prod_q[2] <= $signed({1'b0, color_q.blue}) * W_CR_B;
    cb_prod_q[0] <= $signed({1'b0, color_q.red}) * W_CB_R;
    cb_prod_q[1] <= $signed({1'b0, color_q.green}) * W_CB_G;
    cb_prod_q[2] <= $signed({1'b0, color_q.blue}) * W_CB_B;
  end

  // largest magnitude is 255 * 112, well inside 18 bits
  assign cr_sum = cr_prod_q[0] + cr_prod_q[1] + cr_prod_q[2];
  assign cb_sum = cb_prod_q[0] + cb_prod_q[1] + cb_prod_q[2];

  always_ff @(posedge clk_pixel) begin
    cr_q <= clip_chroma(cr_sum);
    cb_q <= clip_chroma(cb_sum);
  end

  // stage 4: backdrop when both chroma values sit at or under their limit
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      player_o <= 1'b0;
    end else begin
      player_o <= !((cr_q <= cr_upper_i) && (cb_q <= cb_upper_i));
    end
  end

  // color already spent one cycle in color_q
  pipe_delay #(
    .payload_t (keyer_pkg::rgb888_t),
    .DEPTH     (`KEYER_KEY_LATENCY - 1)
  ) u_color_delay (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .data_i       (color_q),
    .data_o       (color_o)
  );

endmodule

// ==== logic/keyer_consts.svh ====
`ifndef KEYER_CONSTS_SVH
`define KEYER_CONSTS_SVH

// active raster geometry
`define KEYER_SCREEN_WIDTH  1280
`define KEYER_SCREEN_HEIGHT 720

// coordinate and accumulator widths
`define KEYER_HCOUNT_W 11
`define KEYER_VCOUNT_W 10
`define KEYER_SUM_W    32
`define KEYER_COUNT_W  21

// rgb to cr/cb weights, result is (sum >>> 8) + offset
`define KEYER_CR_R          112
`define KEYER_CR_G          (-94)
`define KEYER_CR_B          (-18)
`define KEYER_CB_R          (-38)
`define KEYER_CB_G          (-74)
`define KEYER_CB_B          112
`define KEYER_CHROMA_OFFSET 128

// backdrop thresholds used when nothing better is known
`define KEYER_CR_UPPER_DEFAULT 8'd144
`define KEYER_CB_UPPER_DEFAULT 8'd144

// pipeline depths in pixel clocks
`define KEYER_KEY_LATENCY 4
`define KEYER_OUT_LATENCY 5

// display colors
`define KEYER_CROSSHAIR_COLOR 24'hFF0000
`define KEYER_PLAYER_COLOR    24'hFFFFFF
`define KEYER_KEY_COLOR       24'h000000

`endif

// ==== logic/keyer_pkg.sv ====
`include "keyer_consts.svh"

package keyer_pkg;

  // raw frame buffer pixel, 5:6:5
  typedef logic [15:0] rgb565_t;

  // widened pixel, 8 bits per channel
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // raster coordinates
  typedef logic [`KEYER_HCOUNT_W-1:0] hcount_t;
  typedef logic [`KEYER_VCOUNT_W-1:0] vcount_t;

  // tag that rides along beside each pixel
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    // inside the visible area
    logic    active;
    // single cycle after the last active pixel
    logic    frame_end;
  } raster_t;

  // what the overlay paints underneath the crosshair
  typedef enum logic {
    VIEW_CAMERA = 1'b0,
    VIEW_MASK   = 1'b1
  } view_mode_t;

endpackage

// ==== logic/keyer_top.sv ====
`timescale 1ns/100ps
`include "keyer_consts.svh"

module keyer_top (
  input  logic                   clk_pixel,
  input  logic                   recent_reset,
  input  keyer_pkg::rgb565_t     pixel_i,
  input  keyer_pkg::hcount_t     hcount_i,
  input  keyer_pkg::vcount_t     vcount_i,
  input  logic                   active_i,
  input  logic                   frame_end_i,
  input  logic [7:0]             cr_upper_i,
  input  logic [7:0]             cb_upper_i,
  input  keyer_pkg::view_mode_t  view_mode_i,
  input  logic                   crosshair_en_i,
  output keyer_pkg::rgb888_t     pixel_o,
  output logic                   active_o,
  output keyer_pkg::hcount_t     com_x_o,
  output keyer_pkg::vcount_t     com_y_o,
  output logic                   com_valid_o
);

  keyer_pkg::raster_t tag_in;
  keyer_pkg::raster_t tag_key;
  keyer_pkg::rgb888_t color_key;
  logic               player_key;

  // bundle the raster strobes into the tag
  assign tag_in = {hcount_i, vcount_i, active_i, frame_end_i};

  // ==========================================================================
  // keying path, everything below lines up at the key latency
  // ==========================================================================
  chroma_key u_chroma_key (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .pixel_i      (pixel_i),
    .cr_upper_i   (cr_upper_i),
    .cb_upper_i   (cb_upper_i),
    .color_o      (color_key),
    .player_o     (player_key)
  );

  pipe_delay #(
    .payload_t (keyer_pkg::raster_t),
    .DEPTH     (`KEYER_KEY_LATENCY)
  ) u_tag_delay (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .data_i       (tag_in),
    .data_o       (tag_key)
  );

  centroid_tracker u_tracker (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .tag_i        (tag_key),
    .player_i     (player_key),
    .com_x_o      (com_x_o),
    .com_y_o      (com_y_o),
    .com_valid_o  (com_valid_o)
  );

  // final register stage of the pixel path
  overlay_mux u_overlay (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .tag_i          (tag_key),
    .player_i       (player_key),
    .color_i        (color_key),
    .com_x_i        (com_x_o),
    .com_y_i        (com_y_o),
    .view_mode_i    (view_mode_i),
    .crosshair_en_i (crosshair_en_i),
    .pixel_o        (pixel_o),
    .active_o       (active_o)
  );

endmodule

// ==== logic/overlay_mux.sv ====
`timescale 1ns/100ps
`include "keyer_consts.svh"

module overlay_mux (
  input  logic                   clk_pixel,
  input  logic                   recent_reset,
  input  keyer_pkg::raster_t     tag_i,
  input  logic                   player_i,
  input  keyer_pkg::rgb888_t     color_i,
  input  keyer_pkg::hcount_t     com_x_i,
  input  keyer_pkg::vcount_t     com_y_i,
  input  keyer_pkg::view_mode_t  view_mode_i,
  input  logic                   crosshair_en_i,
  output keyer_pkg::rgb888_t     pixel_o,
  output logic                   active_o
);

  keyer_pkg::rgb888_t background;
  keyer_pkg::rgb888_t pixel_next;
  logic               on_crosshair;

  // camera image or binary mask underneath
  always_comb begin
    if (view_mode_i == keyer_pkg::VIEW_MASK) begin
      background = player_i ? keyer_pkg::rgb888_t'(`KEYER_PLAYER_COLOR)
                            : keyer_pkg::rgb888_t'(`KEYER_KEY_COLOR);
    end else begin
      background = color_i;
    end
  end

  // one full column and one full row through the held centroid
  assign on_crosshair = crosshair_en_i &&
                        ((tag_i.hcount == com_x_i) || (tag_i.vcount == com_y_i));

  always_comb begin
    pixel_next = background;
    if (on_crosshair) begin
      pixel_next = keyer_pkg::rgb888_t'(`KEYER_CROSSHAIR_COLOR);
    end
    // blanking is always black
    if (!tag_i.active) begin
      pixel_next = '0;
    end
  end

  // output register, last stage of the pixel path
  always_ff @(posedge clk_pixel) begin
    pixel_o <= pixel_next;
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      active_o <= 1'b0;
    end else begin
      active_o <= tag_i.active;
    end
  end

endmodule

// ==== logic/pipe_delay.sv ====
`timescale 1ns/100ps

module pipe_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk_pixel,
  input  logic     recent_reset,
  input  payload_t data_i,
  output payload_t data_o
);

  // stage 0 takes the input, stage DEPTH-1 drives the output
  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      // flush so no stale strobe bit leaks out after reset
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

// ==== project.f ====
+incdir+logic
logic/keyer_pkg.sv
logic/pipe_delay.sv
logic/chroma_key.sv
logic/centroid_divider.sv
logic/centroid_tracker.sv
logic/overlay_mux.sv
logic/keyer_top.sv
verification/tb_clock_gen.sv
verification/keyer_tb.sv

// ==== verification/keyer_tb.sv ====
`timescale 1ns/100ps
`include "keyer_consts.svh"

module keyer_tb;

  // ==========================================================================
  // test window and run limits
  // ==========================================================================
  localparam int WIN_W        = 64;
  localparam int WIN_H        = 32;
  // blanking between lines is longer than the output latency
  localparam int LINE_GAP     = 8;
  localparam int FRAME_CYCLES = WIN_H * (WIN_W + LINE_GAP) + 2;
  localparam int NUM_FRAMES   = 6;
  localparam int WAIT_WINDOW  = 200;
  localparam int CYCLE_LIMIT  = NUM_FRAMES * (FRAME_CYCLES + WAIT_WINDOW) + 100;

  // frame contents
  localparam int FRAME_RANDOM   = 0;
  localparam int FRAME_RECT     = 1;
  localparam int FRAME_BACKDROP = 2;
  // green keys out and red stays as player
  localparam keyer_pkg::rgb565_t BACKDROP_565 = 16'h07E0;
  localparam keyer_pkg::rgb565_t PLAYER_565   = 16'hF800;
  // player rectangle with exclusive upper bounds
  localparam int RECT_X0 = 20;
  localparam int RECT_X1 = 36;
  localparam int RECT_Y0 = 8;
  localparam int RECT_Y1 = 20;

  logic                  clk_pixel;
  logic                  recent_reset;
  keyer_pkg::rgb565_t    pixel_i;
  keyer_pkg::hcount_t    hcount_i;
  keyer_pkg::vcount_t    vcount_i;
  logic                  active_i;
  logic                  frame_end_i;
  logic [7:0]            cr_upper_i;
  logic [7:0]            cb_upper_i;
  keyer_pkg::view_mode_t view_mode_i;
  logic                  crosshair_en_i;
  keyer_pkg::rgb888_t    pixel_o;
  logic                  active_o;
  keyer_pkg::hcount_t    com_x_o;
  keyer_pkg::vcount_t    com_y_o;
  logic                  com_valid_o;

  // reference state
  string                 test_name;
  logic                  check_en;
  longint                ref_x_sum;
  longint                ref_y_sum;
  longint                ref_count;
  keyer_pkg::hcount_t    ref_com_x;
  keyer_pkg::vcount_t    ref_com_y;
  keyer_pkg::rgb888_t    exp_pixel_q[$];
  logic                  exp_active_q[$];
  int                    pixel_errors;
  int                    strobe_errors;
  int                    coord_errors;
  int                    other_errors;
  int                    cycle_count;

  tb_clock_gen #(.PERIOD_NS(40.0)) u_clock (.clk_o(clk_pixel));

  keyer_top u_dut (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .pixel_i        (pixel_i),
    .hcount_i       (hcount_i),
    .vcount_i       (vcount_i),
    .active_i       (active_i),
    .frame_end_i    (frame_end_i),
    .cr_upper_i     (cr_upper_i),
    .cb_upper_i     (cb_upper_i),
    .view_mode_i    (view_mode_i),
    .crosshair_en_i (crosshair_en_i),
    .pixel_o        (pixel_o),
    .active_o       (active_o),
    .com_x_o        (com_x_o),
    .com_y_o        (com_y_o),
    .com_valid_o    (com_valid_o)
  );

  // ==========================================================================
  // reference model
  // ==========================================================================

  // zero bits appended below each channel
  function automatic keyer_pkg::rgb888_t widen(input keyer_pkg::rgb565_t px);
    keyer_pkg::rgb888_t c;
    c.red   = {px[15:11], 3'b000};
    c.green = {px[10:5], 2'b00};
    c.blue  = {px[4:0], 3'b000};
    return c;
  endfunction

  // weighted sum, arithmetic shift by 8, offset, clip to a byte
  function automatic int chroma(input keyer_pkg::rgb888_t c, input int wr, input int wg,
                                input int wb);
    int r;
    int g;
    int b;
    int level;
    r = c.red;
    g = c.green;
    b = c.blue;
    level = ((r * wr + g * wg + b * wb) >>> 8) + `KEYER_CHROMA_OFFSET;
    if (level < 0) begin
      level = 0;
    end else if (level > 255) begin
      level = 255;
    end
    return level;
  endfunction

  // backdrop only when both chroma values are at or under their limit
  function automatic logic is_player(input keyer_pkg::rgb565_t px, input logic [7:0] cr_up,
                                     input logic [7:0] cb_up);
    int cr;
    int cb;
    cr = chroma(widen(px), `KEYER_CR_R, `KEYER_CR_G, `KEYER_CR_B);
    cb = chroma(widen(px), `KEYER_CB_R, `KEYER_CB_G, `KEYER_CB_B);
    return !((cr <= int'(cr_up)) && (cb <= int'(cb_up)));
  endfunction

  function automatic keyer_pkg::rgb888_t expected_pixel(
    input keyer_pkg::rgb565_t px, input logic act, input keyer_pkg::hcount_t hc,
    input keyer_pkg::vcount_t vc, input keyer_pkg::view_mode_t view, input logic xh_en,
    input logic [7:0] cr_up, input logic [7:0] cb_up, input keyer_pkg::hcount_t cx,
    input keyer_pkg::vcount_t cy);
    // blanking wins over everything
    if (!act) begin
      return '0;
    end
    if (xh_en && ((hc == cx) || (vc == cy))) begin
      return keyer_pkg::rgb888_t'(`KEYER_CROSSHAIR_COLOR);
    end
    if (view == keyer_pkg::VIEW_MASK) begin
      return is_player(px, cr_up, cb_up) ? keyer_pkg::rgb888_t'(`KEYER_PLAYER_COLOR)
                                         : keyer_pkg::rgb888_t'(`KEYER_KEY_COLOR);
    end
    return widen(px);
  endfunction

  function automatic keyer_pkg::rgb565_t frame_pixel(input int kind, input int x, input int y);
    case (kind)
      FRAME_RANDOM: return 16'($urandom);
      FRAME_RECT: begin
        if (x >= RECT_X0 && x < RECT_X1 && y >= RECT_Y0 && y < RECT_Y1) begin
          return PLAYER_565;
        end
        return BACKDROP_565;
      end
      default: return BACKDROP_565;
    endcase
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic compare_pixel(input string name, input keyer_pkg::rgb888_t exp_px,
                               input keyer_pkg::rgb888_t act_px);
    if (act_px !== exp_px) begin
      $display("Mismatch %s: expected pixel %06h, actual %06h at %0t", name, exp_px,
               act_px, $time);
      pixel_errors++;
    end
  endtask

  task automatic compare_coord(input string name, input keyer_pkg::hcount_t exp_x,
                               input keyer_pkg::vcount_t exp_y,
                               input keyer_pkg::hcount_t act_x,
                               input keyer_pkg::vcount_t act_y);
    if (act_x !== exp_x || act_y !== exp_y) begin
      $display("Mismatch %s: expected centroid (%0d, %0d), actual (%0d, %0d)", name,
               exp_x, exp_y, act_x, act_y);
      coord_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp_bit, input logic act_bit);
    if (act_bit !== exp_bit) begin
      $display("Mismatch %s: expected %b, actual %b at %0t", name, exp_bit, act_bit, $time);
      strobe_errors++;
    end
  endtask

  task automatic check_reset_outputs();
    compare_bit({test_name, " active_o"}, 1'b0, active_o);
    compare_bit({test_name, " com_valid_o"}, 1'b0, com_valid_o);
    compare_coord(test_name, '0, '0, com_x_o, com_y_o);
  endtask

  // outputs settle after the rising edge so sample on the falling one
  // the item pushed five cycles ago is due now
  always @(negedge clk_pixel) begin
    if (check_en) begin
      if (exp_pixel_q.size() >= `KEYER_OUT_LATENCY) begin
        compare_pixel(test_name, exp_pixel_q.pop_front(), pixel_o);
        compare_bit({test_name, " active_o"}, exp_active_q.pop_front(), active_o);
      end
      exp_pixel_q.push_back(expected_pixel(pixel_i, active_i, hcount_i, vcount_i,
                                           view_mode_i, crosshair_en_i, cr_upper_i,
                                           cb_upper_i, ref_com_x, ref_com_y));
      exp_active_q.push_back(active_i);
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  task automatic drive_cycle(input keyer_pkg::rgb565_t px, input int hc, input int vc,
                             input logic act, input logic fe);
    @(posedge clk_pixel);
    #2;
    pixel_i     = px;
    hcount_i    = keyer_pkg::hcount_t'(hc);
    vcount_i    = keyer_pkg::vcount_t'(vc);
    active_i    = act;
    frame_end_i = fe;
  endtask

  // one window frame, then the frame end pulse
  task automatic run_frame(input int kind);
    keyer_pkg::rgb565_t px;
    ref_x_sum = 0;
    ref_y_sum = 0;
    ref_count = 0;
    for (int y = 0; y < WIN_H; y++) begin
      for (int x = 0; x < WIN_W; x++) begin
        px = frame_pixel(kind, x, y);
        if (is_player(px, cr_upper_i, cb_upper_i)) begin
          ref_x_sum += x;
          ref_y_sum += y;
          ref_count++;
        end
        drive_cycle(px, x, y, 1'b1, 1'b0);
      end
      for (int g = 0; g < LINE_GAP; g++) begin
        drive_cycle('0, WIN_W + g, y, 1'b0, 1'b0);
      end
    end
    drive_cycle('0, 0, WIN_H, 1'b0, 1'b1);
    drive_cycle('0, 0, WIN_H, 1'b0, 1'b0);
  endtask

  // floor of the mean or no pulse at all for a frame without players
  task automatic check_centroid();
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WAIT_WINDOW) begin
      @(negedge clk_pixel);
      seen = com_valid_o;
      waited++;
    end
    if (ref_count == 0) begin
      if (seen) begin
        $display("%s: com_valid_o pulsed after a frame without player pixels", test_name);
        other_errors++;
      end
    end else if (!seen) begin
      $display("%s: no com_valid_o within %0d cycles of frame end", test_name, WAIT_WINDOW);
      other_errors++;
    end else begin
      ref_com_x = keyer_pkg::hcount_t'(ref_x_sum / ref_count);
      ref_com_y = keyer_pkg::vcount_t'(ref_y_sum / ref_count);
      compare_coord(test_name, ref_com_x, ref_com_y, com_x_o, com_y_o);
    end
    // next settings change lands just after a rising edge
    @(posedge clk_pixel);
    #2;
  endtask

  initial begin
    void'($urandom(11));
    recent_reset   = 1'b1;
    pixel_i        = '0;
    hcount_i       = '0;
    vcount_i       = '0;
    active_i       = 1'b0;
    frame_end_i    = 1'b0;
    cr_upper_i     = `KEYER_CR_UPPER_DEFAULT;
    cb_upper_i     = `KEYER_CB_UPPER_DEFAULT;
    view_mode_i    = keyer_pkg::VIEW_CAMERA;
    crosshair_en_i = 1'b0;
    check_en       = 1'b0;
    ref_com_x      = '0;
    ref_com_y      = '0;
    pixel_errors   = 0;
    strobe_errors  = 0;
    coord_errors   = 0;
    other_errors   = 0;

    // four reset edges with outputs checked while held and just after
    test_name = "reset";
    repeat (3) begin
      @(negedge clk_pixel);
      check_reset_outputs();
    end
    @(posedge clk_pixel);
    #2;
    recent_reset = 1'b0;
    check_en     = 1'b1;
    @(negedge clk_pixel);
    check_reset_outputs();

    test_name = "camera";
    run_frame(FRAME_RANDOM);
    check_centroid();

    // thresholds and view only change while the pipe holds blanking
    test_name   = "mask";
    view_mode_i = keyer_pkg::VIEW_MASK;
    cr_upper_i  = 8'($urandom_range(64, 192));
    cb_upper_i  = 8'($urandom_range(64, 192));
    run_frame(FRAME_RANDOM);
    check_centroid();

    test_name   = "centroid";
    view_mode_i = keyer_pkg::VIEW_CAMERA;
    cr_upper_i  = `KEYER_CR_UPPER_DEFAULT;
    cb_upper_i  = `KEYER_CB_UPPER_DEFAULT;
    run_frame(FRAME_RECT);
    check_centroid();

    test_name      = "crosshair";
    crosshair_en_i = 1'b1;
    run_frame(FRAME_RANDOM);
    check_centroid();

    // all backdrop so the centroid must hold
    test_name      = "empty";
    crosshair_en_i = 1'b0;
    run_frame(FRAME_BACKDROP);
    check_centroid();

    test_name      = "held crosshair";
    crosshair_en_i = 1'b1;
    run_frame(FRAME_RANDOM);
    check_centroid();

    repeat (`KEYER_OUT_LATENCY + 2) @(posedge clk_pixel);
    $display("errors: pixel %0d, strobe %0d, centroid %0d, other %0d", pixel_errors,
             strobe_errors, coord_errors, other_errors);
    if (pixel_errors + strobe_errors + coord_errors + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog sized from six frames plus one divider wait each
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_pixel);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk_o
);

  // free running pixel clock, first rising edge half a period in
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule
